//--- decodePkg.sv
package decodePkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] regIdx_t;
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    localparam int opcodeLsb = 26;
    localparam int rsLsb = 21;
    localparam int rtLsb = 16;
    localparam int rdLsb = 11;
    localparam int shamtLsb = 6;
    localparam int functLsb = 0;

    localparam regIdx_t linkReg = 5'd31; // $ra

    // REGIMM rt bits
    localparam int regimmLinkBit = 4;
    localparam int regimmLikelyBit = 1;
    localparam int regimmGezBit = 0;

    localparam opcode_t opSpecial = 6'b000000;
    localparam opcode_t opRegimm = 6'b000001;
    localparam opcode_t opJ = 6'b000010;
    localparam opcode_t opJal = 6'b000011;
    localparam opcode_t opBeq = 6'b000100;
    localparam opcode_t opBne = 6'b000101;
    localparam opcode_t opBlez = 6'b000110;
    localparam opcode_t opBgtz = 6'b000111;
    localparam opcode_t opAddi = 6'b001000;
    localparam opcode_t opAddiu = 6'b001001;
    localparam opcode_t opSlti = 6'b001010;
    localparam opcode_t opSltiu = 6'b001011;
    localparam opcode_t opAndi = 6'b001100;
    localparam opcode_t opOri = 6'b001101;
    localparam opcode_t opXori = 6'b001110;
    localparam opcode_t opLui = 6'b001111;
    localparam opcode_t opBeql = 6'b010100;
    localparam opcode_t opBnel = 6'b010101;
    localparam opcode_t opBlezl = 6'b010110;
    localparam opcode_t opBgtzl = 6'b010111;
    localparam opcode_t opSpecial2 = 6'b011100;
    localparam opcode_t opLb = 6'b100000;
    localparam opcode_t opLh = 6'b100001;
    localparam opcode_t opLw = 6'b100011;
    localparam opcode_t opLbu = 6'b100100;
    localparam opcode_t opLhu = 6'b100101;
    localparam opcode_t opSb = 6'b101000;
    localparam opcode_t opSh = 6'b101001;
    localparam opcode_t opSw = 6'b101011;

    localparam funct_t fnSll = 6'b000000;
    localparam funct_t fnSrl = 6'b000010;
    localparam funct_t fnSra = 6'b000011;
    localparam funct_t fnSllv = 6'b000100;
    localparam funct_t fnSrlv = 6'b000110;
    localparam funct_t fnSrav = 6'b000111;
    localparam funct_t fnJr = 6'b001000;
    localparam funct_t fnJalr = 6'b001001;
    localparam funct_t fnSyscall = 6'b001100;
    localparam funct_t fnBreak = 6'b001101;
    localparam funct_t fnMfhi = 6'b010000;
    localparam funct_t fnMthi = 6'b010001;
    localparam funct_t fnMflo = 6'b010010;
    localparam funct_t fnMtlo = 6'b010011;
    localparam funct_t fnMult = 6'b011000;
    localparam funct_t fnMultu = 6'b011001;
    localparam funct_t fnDiv = 6'b011010;
    localparam funct_t fnDivu = 6'b011011;
    localparam funct_t fnAdd = 6'b100000;
    localparam funct_t fnAddu = 6'b100001;
    localparam funct_t fnSub = 6'b100010;
    localparam funct_t fnSubu = 6'b100011;
    localparam funct_t fnAnd = 6'b100100;
    localparam funct_t fnOr = 6'b100101;
    localparam funct_t fnXor = 6'b100110;
    localparam funct_t fnNor = 6'b100111;
    localparam funct_t fnSlt = 6'b101010;
    localparam funct_t fnSltu = 6'b101011;

    // SPECIAL2 functs
    localparam funct_t fnMadd = 6'b000000;
    localparam funct_t fnMaddu = 6'b000001;
    localparam funct_t fnMul = 6'b000010;
    localparam funct_t fnMsub = 6'b000100;
    localparam funct_t fnMsubu = 6'b000101;

    typedef enum logic [3:0] {
        classNop, classAluReg, classShiftImm, classShiftVar, classAluImm, classLui,
        classLoad, classStore, classBranchTwoReg, classBranchZero, classJumpImm,
        classJumpReg, classMulOp, classMulMoveFrom, classMulMoveTo, classException
    } opClass_t;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluNor, aluXor,
        aluShiftLeft, aluShiftRight, aluArithShiftRight, aluSlt, aluSltu
    } aluCtrl_t;

    typedef enum logic [3:0] {
        mulDisabled, mulMultiply, mulMultiplyUnsigned, mulDivide, mulDivideUnsigned,
        mulMadd, mulMaddu, mulMsub, mulMsubu, mulSetHi, mulSetLo
    } mulCtrl_t;

    typedef enum logic [2:0] {
        cmpEqual, cmpNotEqual, cmpLessThanZero, cmpLessOrEqualZero,
        cmpGreaterThanZero, cmpGreaterOrEqualZero
    } cmpCtrl_t;

    typedef enum logic [2:0] {grfNone, grfAlu, grfMem, grfPc, grfMul} grfSrc_t;
    typedef enum logic [1:0] {memByte1, memByte2, memByte4} memWidth_t;
    typedef enum logic [1:0] {excNone, excSyscall, excBreak, excUnknown} exc_t;

endpackage

//--- decodeIf.sv
`timescale 1ns/1ns

interface decodeIf;
    import decodePkg::*;

    word_t instr; // registered instruction word
    opClass_t opClass;
    regIdx_t rt;
    logic likely;

    modport producer (
        output instr,
        output opClass,
        output rt,
        output likely
    );

    modport consumer (
        input instr,
        input opClass,
        input rt,
        input likely
    );
endinterface

//--- decodeControl.sv
`timescale 1ns/1ns

module decodeControl #(
    parameter bit implementLikely = 1'b1
) (
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    input  logic bubble,
    input  logic outReady,
    input  decodePkg::word_t instruction,
    output logic inReady,
    output logic outValid,
    output decodePkg::exc_t exception,
    decodeIf.producer dec
);
    import decodePkg::*;

    opcode_t opcode;
    funct_t funct;
    regIdx_t rt;
    opClass_t nextClass;
    exc_t nextExc;
    logic nextLikely;
    logic accept;
    word_t instrQ;
    opClass_t classQ;
    logic likelyQ;

    assign opcode = instruction[opcodeLsb +: 6];
    assign funct = instruction[functLsb +: 6];
    assign rt = instruction[rtLsb +: 5];

    assign inReady = !outValid || outReady; // hold under back-pressure
    assign accept = inValid && inReady;

    always_comb
    begin
        nextClass = classNop;
        nextExc = excNone;
        nextLikely = 1'b0;
        case (opcode)
            opSpecial:
                case (funct)
                    fnAddu, fnSubu, fnAdd, fnSub, fnAnd, fnOr, fnNor, fnXor, fnSlt, fnSltu:
                        nextClass = classAluReg;
                    fnSll, fnSrl, fnSra: nextClass = classShiftImm;
                    fnSllv, fnSrlv, fnSrav: nextClass = classShiftVar;
                    fnJr, fnJalr: nextClass = classJumpReg;
                    fnMult, fnMultu, fnDiv, fnDivu: nextClass = classMulOp;
                    fnMfhi, fnMflo: nextClass = classMulMoveFrom;
                    fnMthi, fnMtlo: nextClass = classMulMoveTo;
                    fnSyscall: nextExc = excSyscall;
                    fnBreak: nextExc = excBreak;
                    default: nextExc = excUnknown;
                endcase
            opSpecial2:
                case (funct)
                    fnMadd, fnMaddu, fnMsub, fnMsubu, fnMul: nextClass = classMulOp;
                    default: nextExc = excUnknown;
                endcase
            opRegimm:
                if (rt[3:2] == 2'b00) // bltz/bgez family, with link and likely bits
                begin
                    nextClass = classBranchZero;
                    nextLikely = rt[regimmLikelyBit];
                end
                else
                    nextExc = excUnknown;
            opBeq, opBne: nextClass = classBranchTwoReg;
            opBlez, opBgtz: nextClass = classBranchZero;
            opBeql, opBnel:
            begin
                nextClass = classBranchTwoReg;
                nextLikely = 1'b1;
            end
            opBlezl, opBgtzl:
            begin
                nextClass = classBranchZero;
                nextLikely = 1'b1;
            end
            opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori: nextClass = classAluImm;
            opLui: nextClass = classLui;
            opLb, opLh, opLw, opLbu, opLhu: nextClass = classLoad;
            opSb, opSh, opSw: nextClass = classStore;
            opJ, opJal: nextClass = classJumpImm;
            default: nextExc = excUnknown;
        endcase

        if (nextLikely && !implementLikely)
            nextExc = excUnknown;
        if (nextExc != excNone)
        begin
            nextClass = classException;
            nextLikely = 1'b0;
        end
        if (bubble) // squashed slot
        begin
            nextClass = classNop;
            nextExc = excNone;
            nextLikely = 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            outValid <= 1'b0;
            classQ <= classNop;
            exception <= excNone;
            likelyQ <= 1'b0;
        end
        else if (accept)
        begin
            outValid <= 1'b1;
            classQ <= nextClass;
            exception <= nextExc;
            likelyQ <= nextLikely;
        end
        else if (outReady)
            outValid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            instrQ <= instruction;
    end

    assign dec.instr = instrQ;
    assign dec.opClass = classQ;
    assign dec.rt = instrQ[rtLsb +: 5];
    assign dec.likely = likelyQ;
endmodule

//--- operandDecode.sv
`timescale 1ns/1ns

module operandDecode (
    decodeIf.consumer dec,
    output decodePkg::regIdx_t regRead1,
    output decodePkg::regIdx_t regRead2,
    output decodePkg::regIdx_t destReg,
    output decodePkg::grfSrc_t grfSource,
    output decodePkg::word_t immediate
);
    import decodePkg::*;

    opcode_t opcode;
    funct_t funct;
    regIdx_t rs;
    regIdx_t rd;
    logic [15:0] imm16;
    word_t signImm;
    logic link;

    assign opcode = dec.instr[opcodeLsb +: 6];
    assign funct = dec.instr[functLsb +: 6];
    assign rs = dec.instr[rsLsb +: 5];
    assign rd = dec.instr[rdLsb +: 5];
    assign imm16 = dec.instr[15:0];
    assign signImm = {{16{imm16[15]}}, imm16};

    always_comb
    begin
        case (dec.opClass)
            classBranchZero: link = opcode == opRegimm && dec.rt[regimmLinkBit]; // bltzal, bgezal
            classJumpImm: link = opcode == opJal;
            classJumpReg: link = funct == fnJalr;
            default: link = 1'b0;
        endcase
    end

    always_comb
    begin
        regRead1 = '0;
        regRead2 = '0;
        destReg = '0;
        grfSource = grfNone;
        immediate = '0;
        case (dec.opClass)
            classAluReg, classShiftVar:
            begin
                // variable shifts take the amount from rs
                regRead1 = dec.opClass == classShiftVar ? dec.rt : rs;
                regRead2 = dec.opClass == classShiftVar ? rs : dec.rt;
                destReg = rd;
                grfSource = grfAlu;
            end
            classShiftImm:
            begin
                regRead1 = dec.rt;
                destReg = rd;
                grfSource = grfAlu;
                immediate = word_t'(dec.instr[shamtLsb +: 5]);
            end
            classAluImm, classLui:
            begin
                regRead1 = rs;
                destReg = dec.rt;
                grfSource = grfAlu;
                if (dec.opClass == classLui)
                    immediate = {imm16, 16'b0};
                else if (opcode == opAndi || opcode == opOri || opcode == opXori)
                    immediate = {16'b0, imm16}; // logical ops zero-extend
                else
                    immediate = signImm;
            end
            classLoad:
            begin
                regRead1 = rs;
                destReg = dec.rt;
                grfSource = grfMem;
                immediate = signImm;
            end
            classStore, classBranchTwoReg:
            begin
                regRead1 = rs;
                regRead2 = dec.rt;
                immediate = signImm;
            end
            classBranchZero:
            begin
                regRead1 = rs;
                immediate = signImm;
            end
            classJumpImm: immediate = word_t'(dec.instr[25:0]);
            classJumpReg: regRead1 = rs;
            classMulOp:
            begin
                regRead1 = rs;
                regRead2 = dec.rt;
                if (opcode == opSpecial2 && funct == fnMul)
                begin
                    destReg = rd;
                    grfSource = grfMul;
                end
            end
            classMulMoveFrom:
            begin
                destReg = rd;
                grfSource = grfMul;
            end
            classMulMoveTo: regRead1 = rs;
            default: ;
        endcase

        if (link)
        begin
            grfSource = grfPc;
            destReg = dec.opClass == classJumpReg ? rd : linkReg; // jalr names its own target
        end
    end
endmodule

//--- executeDecode.sv
`timescale 1ns/1ns

module executeDecode (
    decodeIf.consumer dec,
    output decodePkg::aluCtrl_t aluCtrl,
    output logic aluSrc,
    output logic checkOverflow,
    output logic mulEnable,
    output logic mulOutputSel,
    output decodePkg::mulCtrl_t mulCtrl
);
    import decodePkg::*;

    opcode_t opcode;
    funct_t funct;

    assign opcode = dec.instr[opcodeLsb +: 6];
    assign funct = dec.instr[functLsb +: 6];

    always_comb
    begin
        aluCtrl = aluAdd;
        aluSrc = 1'b0;
        checkOverflow = 1'b0;
        mulCtrl = mulDisabled;
        mulOutputSel = 1'b0;
        case (dec.opClass)
            classAluReg, classShiftImm, classShiftVar:
            begin
                aluSrc = dec.opClass == classShiftImm; // shamt comes as immediate
                checkOverflow = funct == fnAdd || funct == fnSub;
                case (funct)
                    fnSub, fnSubu: aluCtrl = aluSub;
                    fnAnd: aluCtrl = aluAnd;
                    fnOr: aluCtrl = aluOr;
                    fnNor: aluCtrl = aluNor;
                    fnXor: aluCtrl = aluXor;
                    fnSll, fnSllv: aluCtrl = aluShiftLeft;
                    fnSrl, fnSrlv: aluCtrl = aluShiftRight;
                    fnSra, fnSrav: aluCtrl = aluArithShiftRight;
                    fnSlt: aluCtrl = aluSlt;
                    fnSltu: aluCtrl = aluSltu;
                    default: aluCtrl = aluAdd; // add, addu
                endcase
            end
            classAluImm:
            begin
                aluSrc = 1'b1;
                checkOverflow = opcode == opAddi;
                case (opcode)
                    opAndi: aluCtrl = aluAnd;
                    opOri: aluCtrl = aluOr;
                    opXori: aluCtrl = aluXor;
                    opSlti: aluCtrl = aluSlt;
                    opSltiu: aluCtrl = aluSltu;
                    default: aluCtrl = aluAdd;
                endcase
            end
            classLui: aluSrc = 1'b1; // shifted immediate plus rs=0
            classMulOp:
                if (opcode == opSpecial2)
                    case (funct)
                        fnMadd: mulCtrl = mulMadd;
                        fnMaddu: mulCtrl = mulMaddu;
                        fnMsub: mulCtrl = mulMsub;
                        fnMsubu: mulCtrl = mulMsubu;
                        default: mulCtrl = mulMultiply; // mul, result read from lo
                    endcase
                else
                    case (funct)
                        fnMultu: mulCtrl = mulMultiplyUnsigned;
                        fnDiv: mulCtrl = mulDivide;
                        fnDivu: mulCtrl = mulDivideUnsigned;
                        default: mulCtrl = mulMultiply;
                    endcase
            classMulMoveFrom: mulOutputSel = funct == fnMfhi;
            classMulMoveTo:
                if (funct == fnMthi)
                    mulCtrl = mulSetHi;
                else
                    mulCtrl = mulSetLo;
            default: ;
        endcase
    end

    assign mulEnable = mulCtrl != mulDisabled;
endmodule

//--- flowDecode.sv
`timescale 1ns/1ns

module flowDecode (
    decodeIf.consumer dec,
    output logic branch,
    output logic branchLikely,
    output logic absJump,
    output logic absJumpFromReg,
    output decodePkg::cmpCtrl_t cmpCtrl
);
    import decodePkg::*;

    opcode_t opcode;

    assign opcode = dec.instr[opcodeLsb +: 6];

    always_comb
    begin
        branch = 1'b0;
        cmpCtrl = cmpEqual;
        absJump = 1'b0;
        absJumpFromReg = 1'b0;
        case (dec.opClass)
            classBranchTwoReg:
            begin
                branch = 1'b1;
                if (opcode[0]) // bne, bnel
                    cmpCtrl = cmpNotEqual;
            end
            classBranchZero:
            begin
                branch = 1'b1;
                if (opcode == opRegimm && dec.rt[regimmGezBit])
                    cmpCtrl = cmpGreaterOrEqualZero;
                else if (opcode == opRegimm)
                    cmpCtrl = cmpLessThanZero;
                else if (opcode[0]) // bgtz, bgtzl
                    cmpCtrl = cmpGreaterThanZero;
                else
                    cmpCtrl = cmpLessOrEqualZero;
            end
            classJumpImm: absJump = 1'b1;
            classJumpReg:
            begin
                absJump = 1'b1;
                absJumpFromReg = 1'b1;
            end
            default: ;
        endcase
    end

    assign branchLikely = branch && dec.likely;
endmodule

//--- memDecode.sv
`timescale 1ns/1ns

module memDecode (
    decodeIf.consumer dec,
    output logic memLoad,
    output logic memStore,
    output logic memSignExtend,
    output logic calcAddress,
    output decodePkg::memWidth_t memWidth
);
    import decodePkg::*;

    opcode_t opcode;

    assign opcode = dec.instr[opcodeLsb +: 6];
    assign memLoad = dec.opClass == classLoad;
    assign memStore = dec.opClass == classStore;
    assign calcAddress = memLoad || memStore; // base plus offset

    always_comb
    begin
        memWidth = memByte1;
        if (calcAddress)
            case (opcode[1:0])
                2'b00: memWidth = memByte1;
                2'b01: memWidth = memByte2;
                default: memWidth = memByte4;
            endcase
    end

    // lbu and lhu differ from lb and lh in opcode bit 2
    assign memSignExtend = memLoad && !opcode[2] && memWidth != memByte4;
endmodule

//--- instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder #(
    parameter bit implementLikely = 1'b1
) (
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    output logic inReady,
    input  decodePkg::word_t instruction,
    input  logic bubble,
    output logic outValid,
    input  logic outReady,
    output decodePkg::regIdx_t regRead1,
    output decodePkg::regIdx_t regRead2,
    output decodePkg::regIdx_t destReg,
    output decodePkg::grfSrc_t grfSource,
    output decodePkg::word_t immediate,
    output decodePkg::aluCtrl_t aluCtrl,
    output logic aluSrc,
    output logic checkOverflow,
    output decodePkg::mulCtrl_t mulCtrl,
    output logic mulEnable,
    output logic mulOutputSel,
    output logic branch,
    output logic branchLikely,
    output decodePkg::cmpCtrl_t cmpCtrl,
    output logic absJump,
    output logic absJumpFromReg,
    output logic memLoad,
    output logic memStore,
    output decodePkg::memWidth_t memWidth,
    output logic memSignExtend,
    output logic calcAddress,
    output decodePkg::exc_t exception
);
    decodeIf dec ();

    decodeControl #(.implementLikely(implementLikely)) control (.*); // one-cycle register
    operandDecode operands (.*);
    executeDecode execute (.*);
    flowDecode flow (.*);
    memDecode memory (.*);
endmodule

//--- tbInstrDecoder.sv
`timescale 1ns/1ns

module tbInstrDecoder;
    import decodePkg::*;

    localparam int maxPatterns = 64;
    localparam int numFields = 19;
    localparam int passes = 2; // back-to-back pass, then a stalled pass
    localparam int bundleWidth = 77;
    localparam string patternFile = "decoderPatterns.txt";

    logic clk = 1'b0;
    logic rst;
    logic inValid;
    logic inReady;
    word_t instruction;
    logic bubble;
    logic outValid;
    logic outReady = 1'b1;
    regIdx_t regRead1;
    regIdx_t regRead2;
    regIdx_t destReg;
    grfSrc_t grfSource;
    word_t immediate;
    aluCtrl_t aluCtrl;
    logic aluSrc;
    logic checkOverflow;
    mulCtrl_t mulCtrl;
    logic mulEnable;
    logic mulOutputSel;
    logic branch;
    logic branchLikely;
    cmpCtrl_t cmpCtrl;
    logic absJump;
    logic absJumpFromReg;
    logic memLoad;
    logic memStore;
    memWidth_t memWidth;
    logic memSignExtend;
    logic calcAddress;
    exc_t exception;

    word_t patInstr [maxPatterns];
    logic [31:0] patBubble [maxPatterns];
    logic [31:0] patExp [maxPatterns][numFields];
    string fieldNames [numFields] = '{
        "regRead1", "regRead2", "destReg", "grfSource", "immediate", "aluCtrl", "aluSrc",
        "checkOverflow", "mulCtrl", "mulEnable", "branch", "branchLikely", "cmpCtrl",
        "absJump", "memLoad", "memStore", "memWidth", "memSignExtend", "exception"
    };

    int numPatterns = 0;
    int total = 0;
    int seen = 0; // outputs taken by the sink
    int cycle = 0;
    int acceptCycle;
    int checks = 0;
    int valueErrors = 0;
    int otherErrors = 0;
    int acceptQ [$];
    bit fresh = 1'b1;
    bit stallMode = 1'b0;
    logic [31:0] lfsrState = 32'h8e7cb183;
    logic [bundleWidth-1:0] held;

    instrDecoder #(.implementLikely(1'b1)) dut (.*);

    always #4 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    function automatic logic [31:0] nextLfsr(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0]; // x^32+x^22+x^2+x+1
        return {state[30:0], feedback};
    endfunction

    function automatic logic [bundleWidth-1:0] outputBundle();
        return {regRead1, regRead2, destReg, grfSource, immediate, aluCtrl, aluSrc,
                checkOverflow, mulCtrl, mulEnable, mulOutputSel, branch, branchLikely,
                cmpCtrl, absJump, absJumpFromReg, memLoad, memStore, memWidth,
                memSignExtend, calcAddress, exception};
    endfunction

    task automatic loadPatterns(output int count);
        int fd;
        int got;
        string line;
        count = 0;
        fd = $fopen(patternFile, "r");
        if (fd == 0)
        begin
            $display("could not open the pattern file %s", patternFile);
            otherErrors++;
        end
        else
        begin
            while (!$feof(fd) && count < maxPatterns)
            begin
                if ($fgets(line, fd) == 0)
                    break;
                if (line.len() < 8 || line.substr(0, 1) == "//")
                    continue;
                got = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    patInstr[count], patBubble[count],
                    patExp[count][0], patExp[count][1], patExp[count][2], patExp[count][3],
                    patExp[count][4], patExp[count][5], patExp[count][6], patExp[count][7],
                    patExp[count][8], patExp[count][9], patExp[count][10], patExp[count][11],
                    patExp[count][12], patExp[count][13], patExp[count][14], patExp[count][15],
                    patExp[count][16], patExp[count][17], patExp[count][18]);
                if (got == numFields + 2)
                    count++;
                else
                begin
                    $display("malformed pattern line: %s", line);
                    otherErrors++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic expectZero(input string name, input logic [31:0] value);
        checks++;
        if (value !== 32'h0)
        begin
            $display("error: %s got 0x%0h expected 0x0 after reset", name, value);
            valueErrors++;
        end
    endtask

    task automatic checkIdle();
        expectZero("outValid", 32'(outValid));
        expectZero("branch", 32'(branch));
        expectZero("branchLikely", 32'(branchLikely));
        expectZero("absJump", 32'(absJump));
        expectZero("absJumpFromReg", 32'(absJumpFromReg));
        expectZero("memLoad", 32'(memLoad));
        expectZero("memStore", 32'(memStore));
        expectZero("mulEnable", 32'(mulEnable));
        expectZero("calcAddress", 32'(calcAddress));
        expectZero("grfSource", 32'(grfSource)); // none
        expectZero("exception", 32'(exception)); // none
    endtask

    task automatic compareOutputs(input int idx);
        logic [31:0] got [numFields];
        logic plain;
        logic expOutSel;
        logic expFromReg;
        logic expCalc;
        got[0] = 32'(regRead1);
        got[1] = 32'(regRead2);
        got[2] = 32'(destReg);
        got[3] = 32'(grfSource);
        got[4] = immediate;
        got[5] = 32'(aluCtrl);
        got[6] = 32'(aluSrc);
        got[7] = 32'(checkOverflow);
        got[8] = 32'(mulCtrl);
        got[9] = 32'(mulEnable);
        got[10] = 32'(branch);
        got[11] = 32'(branchLikely);
        got[12] = 32'(cmpCtrl);
        got[13] = 32'(absJump);
        got[14] = 32'(memLoad);
        got[15] = 32'(memStore);
        got[16] = 32'(memWidth);
        got[17] = 32'(memSignExtend);
        got[18] = 32'(exception);
        for (int k = 0; k < numFields; k++)
        begin
            checks++;
            if (got[k] !== patExp[idx][k])
            begin
                $display("error: %s got 0x%0h expected 0x%0h (pattern %0d, instruction 0x%08h)",
                    fieldNames[k], got[k], patExp[idx][k], idx, patInstr[idx]);
                valueErrors++;
            end
        end

        plain = patBubble[idx][0] == 1'b0 && patInstr[idx][31:26] == opSpecial;
        expOutSel = plain && patInstr[idx][5:0] == fnMfhi;
        // j and jal have their own opcodes, jr and jalr sit under SPECIAL
        expFromReg = patExp[idx][13][0] && patInstr[idx][31:26] == opSpecial;
        expCalc = patExp[idx][14][0] || patExp[idx][15][0];
        checks += 3;
        if (mulOutputSel !== expOutSel)
        begin
            $display("error: mulOutputSel got 0x%0h expected 0x%0h (pattern %0d)",
                mulOutputSel, expOutSel, idx);
            valueErrors++;
        end
        if (absJumpFromReg !== expFromReg)
        begin
            $display("error: absJumpFromReg got 0x%0h expected 0x%0h (pattern %0d)",
                absJumpFromReg, expFromReg, idx);
            valueErrors++;
        end
        if (calcAddress !== expCalc)
        begin
            $display("error: calcAddress got 0x%0h expected 0x%0h (pattern %0d)",
                calcAddress, expCalc, idx);
            valueErrors++;
        end
    endtask

    task automatic sendPattern(input int idx);
        int waits;
        waits = 0;
        inValid <= 1'b1;
        instruction <= patInstr[idx];
        bubble <= patBubble[idx][0];
        @(posedge clk);
        while (!inReady)
        begin
            waits++;
            @(posedge clk);
        end
        acceptQ.push_back(cycle); // accepted at this edge
        if (!stallMode && waits != 0)
        begin
            $display("back-to-back acceptance stalled for pattern %0d", idx);
            otherErrors++;
        end
    endtask

    task automatic runPass();
        for (int i = 0; i < numPatterns; i++)
            sendPattern(i);
        inValid <= 1'b0;
        bubble <= 1'b0;
    endtask

    // sink with random back-pressure in the second pass
    always @(posedge clk)
    begin
        if (stallMode)
        begin
            lfsrState = nextLfsr(lfsrState);
            outReady <= lfsrState[0];
        end
        else
            outReady <= 1'b1;
    end

    always @(posedge clk)
    begin
        if (outValid === 1'b1)
        begin
            if (fresh)
            begin
                if (seen >= total || acceptQ.size() == 0)
                begin
                    $display("output appeared without a matching accepted instruction");
                    otherErrors++;
                end
                else
                begin
                    acceptCycle = acceptQ.pop_front();
                    if (cycle != acceptCycle + 1)
                    begin
                        $display("output %0d appeared %0d cycles after acceptance instead of 1",
                            seen, cycle - acceptCycle);
                        otherErrors++;
                    end
                    compareOutputs(seen % numPatterns);
                end
                held = outputBundle();
                fresh = 1'b0;
            end
            else if (outputBundle() !== held)
            begin
                $display("outputs changed while outValid was high and outReady low (output %0d)",
                    seen);
                otherErrors++;
            end
            if (outReady)
            begin
                seen++;
                fresh = 1'b1;
            end
        end
    end

    initial
    begin
        wait (numPatterns > 0);
        repeat (20 * passes * numPatterns + 100) @(posedge clk);
        $display("timeout with %0d of %0d outputs seen", seen, passes * numPatterns);
        $display("Test failures found");
        $finish;
    end

    initial
    begin
        rst = 1'b1;
        inValid = 1'b0;
        instruction = '0;
        bubble = 1'b0;
        loadPatterns(numPatterns);
        if (numPatterns == 0)
        begin
            $display("no patterns were loaded from %s", patternFile);
            $display("Test failures found");
            $finish;
        end
        else
        begin
            total = passes * numPatterns;
            repeat (4) @(posedge clk);
            rst <= 1'b0;
            @(posedge clk);
            checkIdle();
            runPass();
            wait (seen == numPatterns);
            @(posedge clk);
            stallMode <= 1'b1;
            @(posedge clk);
            runPass();
            wait (seen == total);
            repeat (5) @(posedge clk);
            if (outValid !== 1'b0 || acceptQ.size() != 0)
            begin
                $display("extra output or unmatched acceptance left after the last pattern");
                otherErrors++;
            end
            $display("checks: %0d, value errors: %0d, other errors: %0d",
                checks, valueErrors, otherErrors);
            if (valueErrors + otherErrors == 0)
                $display("All tests passed!");
            else
                $display("Test failures found");
            $finish;
        end
    end
endmodule

//--- decoderPatterns.txt
// instr bubble rd1 rd2 dst grf imm alu aluSrc ovf mul mulEn br likely cmp jump ld st width sext exc
// every column in hex, enum columns use the package codes
00432021 0 02 03 04 1 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 // addu
00432022 0 02 03 04 1 00000000 1 0 1 0 0 0 0 0 0 0 0 0 0 0 // sub
0043202b 0 02 03 04 1 00000000 a 0 0 0 0 0 0 0 0 0 0 0 0 0 // sltu
00032140 0 03 00 04 1 00000005 6 1 0 0 0 0 0 0 0 0 0 0 0 0 // sll
00032043 0 03 00 04 1 00000001 8 1 0 0 0 0 0 0 0 0 0 0 0 0 // sra
00432006 0 03 02 04 1 00000000 7 0 0 0 0 0 0 0 0 0 0 0 0 0 // srlv
24a68001 0 05 00 06 1 ffff8001 0 1 0 0 0 0 0 0 0 0 0 0 0 0 // addiu
20a67fff 0 05 00 06 1 00007fff 0 1 1 0 0 0 0 0 0 0 0 0 0 0 // addi
30a68000 0 05 00 06 1 00008000 2 1 0 0 0 0 0 0 0 0 0 0 0 0 // andi
34a6f0f0 0 05 00 06 1 0000f0f0 3 1 0 0 0 0 0 0 0 0 0 0 0 0 // ori
28a6fffe 0 05 00 06 1 fffffffe 9 1 0 0 0 0 0 0 0 0 0 0 0 0 // slti
2ca68000 0 05 00 06 1 ffff8000 a 1 0 0 0 0 0 0 0 0 0 0 0 0 // sltiu
3c06abcd 0 00 00 06 1 abcd0000 0 1 0 0 0 0 0 0 0 0 0 0 0 0 // lui
8ca6fff0 0 05 00 06 2 fffffff0 0 0 0 0 0 0 0 0 0 1 0 2 0 0 // lw
84a60010 0 05 00 06 2 00000010 0 0 0 0 0 0 0 0 0 1 0 1 1 0 // lh
90a60004 0 05 00 06 2 00000004 0 0 0 0 0 0 0 0 0 1 0 0 0 0 // lbu
aca60008 0 05 06 00 0 00000008 0 0 0 0 0 0 0 0 0 0 1 2 0 0 // sw
a4a6fffe 0 05 06 00 0 fffffffe 0 0 0 0 0 0 0 0 0 0 1 1 0 0 // sh
10a6fffc 0 05 06 00 0 fffffffc 0 0 0 0 0 1 0 0 0 0 0 0 0 0 // beq
14a60003 0 05 06 00 0 00000003 0 0 0 0 0 1 0 1 0 0 0 0 0 0 // bne
18a00010 0 05 00 00 0 00000010 0 0 0 0 0 1 0 3 0 0 0 0 0 0 // blez
04a10020 0 05 00 00 0 00000020 0 0 0 0 0 1 0 5 0 0 0 0 0 0 // bgez
04b00020 0 05 00 1f 3 00000020 0 0 0 0 0 1 0 2 0 0 0 0 0 0 // bltzal
50a60004 0 05 06 00 0 00000004 0 0 0 0 0 1 1 0 0 0 0 0 0 0 // beql
04b30004 0 05 00 1f 3 00000004 0 0 0 0 0 1 1 5 0 0 0 0 0 0 // bgezall
09234567 0 00 00 00 0 01234567 0 0 0 0 0 0 0 0 1 0 0 0 0 0 // j
0fffffff 0 00 00 1f 3 03ffffff 0 0 0 0 0 0 0 0 1 0 0 0 0 0 // jal
03e00008 0 1f 00 00 0 00000000 0 0 0 0 0 0 0 0 1 0 0 0 0 0 // jr
00403809 0 02 00 07 3 00000000 0 0 0 0 0 0 0 0 1 0 0 0 0 0 // jalr
00430019 0 02 03 00 0 00000000 0 0 0 2 1 0 0 0 0 0 0 0 0 0 // multu
0043001a 0 02 03 00 0 00000000 0 0 0 3 1 0 0 0 0 0 0 0 0 0 // div
70430001 0 02 03 00 0 00000000 0 0 0 6 1 0 0 0 0 0 0 0 0 0 // maddu
70432002 0 02 03 04 4 00000000 0 0 0 1 1 0 0 0 0 0 0 0 0 0 // mul
00002010 0 00 00 04 4 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 // mfhi
00400013 0 02 00 00 0 00000000 0 0 0 a 1 0 0 0 0 0 0 0 0 0 // mtlo
0000000c 0 00 00 00 0 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 1 // syscall
0000000d 0 00 00 00 0 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 2 // break
fc000000 0 00 00 00 0 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 3 // unused opcode
00432021 1 00 00 00 0 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 // addu, bubbled
8ca6fff0 1 00 00 00 0 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 // lw, bubbled

//--- filelist.f
decodePkg.sv
decodeIf.sv
decodeControl.sv
operandDecode.sv
executeDecode.sv
flowDecode.sv
memDecode.sv
instrDecoder.sv
tbInstrDecoder.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tbInstrDecoder
LINT_TOP ?= instrDecoder
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_MSG ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
